// File: verif/program_input.txt
# P <imem word addr> <instruction>, hex, loaded while run is low
# E <register> <value>, hex, expected register writes in program order
P 00 20080005  # addi t0, zero, 5
P 01 2009fffd  # addi t1, zero, -3
P 02 01095020  # add  t2, t0, t1
P 03 01485822  # sub  t3, t2, t0
P 04 0128802a  # slt  s0, t1, t0
P 05 0109882a  # slt  s1, t0, t1
P 06 01099025  # or   s2, t0, t1
P 07 3133ff0f  # andi s3, t1, 0xff0f
P 08 34141234  # ori  s4, zero, 0x1234
P 09 01080020  # add  zero, t0, t0
P 0a 20150077  # addi s5, zero, 0x77
P 0b ac15000c  # sw   s5, 12(zero)
P 0c 8c16000c  # lw   s6, 12(zero)
P 0d 02d5b820  # add  s7, s6, s5
P 0e 12d50001  # beq  s6, s5, +1 taken
P 0f 20080099  # addi t0, zero, 0x99 skipped
P 10 16d50001  # bne  s6, s5, +1 not taken
P 11 20090011  # addi t1, zero, 0x11
P 12 15200001  # bne  t1, zero, +1 taken
P 13 200a0055  # addi t2, zero, 0x55 skipped
P 14 0c000017  # jal  23
P 15 200b0066  # addi t3, zero, 0x66 flushed
P 16 200b0067  # addi t3, zero, 0x67 never fetched
P 17 08000019  # j    25
P 18 200b0068  # addi t3, zero, 0x68 flushed
P 19 20020004  # addi v0, zero, 4
P 1a 0000000c  # syscall, no effect
P 1b 2002000a  # addi v0, zero, 10
P 1c 0000000c  # syscall, halt
P 1d 200801ee  # addi t0, zero, 0x1ee after halt
P 1e 200901ef  # addi t1, zero, 0x1ef after halt
P 1f 00000000  # nop
E 08 00000005
E 09 fffffffd
E 0a 00000002
E 0b fffffffd
E 10 00000001
E 11 00000000
E 12 fffffffd
E 13 0000ff0d
E 14 00001234
E 15 00000077
E 16 00000077
E 17 000000ee
E 09 00000011
E 1f 00000054
E 02 00000004
E 02 0000000a

// File: mips_core.f
+incdir+include
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/hazard_unit.sv
rtl/mips_core.sv
verif/mips_core_props.sv
verif/tb_mips_core.sv

// File: Makefile
TOP = tb_mips_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f mips_core.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f mips_core.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: verif/tb_mips_core.sv
`include "mips_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;
    import pipe_pkg::*;

    localparam int RUN_TIMEOUT  = 500;
    localparam int QUIET_CYCLES = 20;

    logic                     clk;
    logic                     rst_n;
    logic                     run;
    logic                     prog_we;
    logic [`MIPS_IMEM_AW-1:0] prog_addr;
    word_t                    prog_data;
    logic                     wb_we;
    reg_t                     wb_addr;
    word_t                    wb_data;
    logic                     halted;

    logic [`MIPS_IMEM_AW-1:0] load_addr_q [$];
    word_t                    load_word_q [$];
    reg_t                     exp_reg_q [$];
    word_t                    exp_val_q [$];
    int                       exp_idx;

    mips_core DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .wb_we     (wb_we),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .halted    (halted)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    // P lines fill the program, E lines the expected trace
    task automatic read_input_file();
        int                fd;
        int                n;
        logic [8*100-1:0]  line;
        logic [7:0]        tag;
        logic [31:0]       a;
        logic [31:0]       b;
        fd = $fopen("verif/program_input.txt", "r");
        assert (fd != 0) else abort_run("cannot open verif/program_input.txt");
        while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%s %h %h", tag, a, b);
            if (n == 3 && tag == "P") begin
                load_addr_q.push_back(a[`MIPS_IMEM_AW-1:0]);
                load_word_q.push_back(b);
            end else if (n == 3 && tag == "E") begin
                exp_reg_q.push_back(a[`MIPS_RA_W-1:0]);
                exp_val_q.push_back(b);
            end
        end
        $fclose(fd);
        assert (load_addr_q.size() > 0 && exp_reg_q.size() > 0)
            else abort_run("input file holds no program or no expected trace");
    endtask

    task automatic check_idle();
        assert (wb_we == 1'b0) else begin
            $display("ERROR t=%0t wb_we got %b expected 0", $time, wb_we);
            abort_run("register write while the core is stopped");
        end
        assert (halted == 1'b0) else begin
            $display("ERROR t=%0t halted got %b expected 0", $time, halted);
            abort_run("core halted before it was started");
        end
    endtask

    // run is low here, so nothing may reach the trace
    task automatic load_program();
        int i;
        for (i = 0; i < load_addr_q.size(); i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= load_addr_q[i];
            prog_data <= load_word_q[i];
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic check_write();
        reg_t  er;
        word_t ev;
        assert (exp_idx < exp_reg_q.size()) else begin
            $display("ERROR t=%0t wb_addr got %0d expected none", $time, wb_addr);
            abort_run("more register writes than expected");
        end
        er = exp_reg_q[exp_idx];
        ev = exp_val_q[exp_idx];
        assert (wb_addr == er) else begin
            $display("ERROR t=%0t wb_addr got %0d expected %0d", $time, wb_addr, er);
            abort_run("register write went to the wrong register");
        end
        assert (wb_data == ev) else begin
            $display("ERROR t=%0t wb_data got %h expected %h", $time, wb_data, ev);
            abort_run("register write carried the wrong value");
        end
        exp_idx++;
    endtask

    task automatic run_until_halt();
        int cycles;
        cycles = 0;
        while (!halted) begin
            @(negedge clk);
            if (wb_we) begin
                check_write();
            end
            cycles++;
            assert (cycles < RUN_TIMEOUT) else abort_run("timeout waiting for halted");
        end
    endtask

    task automatic check_quiet_after_halt();
        int i;
        for (i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            assert (wb_we == 1'b0) else begin
                $display("ERROR t=%0t wb_we got %b expected 0", $time, wb_we);
                abort_run("register write after halt");
            end
            assert (halted == 1'b1) else begin
                $display("ERROR t=%0t halted got %b expected 1", $time, halted);
                abort_run("halted fell without reset");
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        exp_idx   = 0;
        read_input_file();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle();
        load_program();
        @(posedge clk);
        run <= 1'b1;
        run_until_halt();
        check_quiet_after_halt();
        if (exp_idx == exp_reg_q.size()) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("only %0d of %0d expected writes seen", exp_idx, exp_reg_q.size());
            abort_run("core halted before the trace was complete");
        end
    end

endmodule

`default_nettype wire

// File: verif/mips_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_props (
    input logic           clk,
    input logic           rst_n,
    input logic           wb_we,
    input pipe_pkg::reg_t wb_addr,
    input logic           halted
);

    // sticky until reset
    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
        else $error("halted dropped without reset");

    quiet_when_halted: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !wb_we)
        else $error("register write while halted");

    no_r0_trace: assert property (@(posedge clk) disable iff (!rst_n) wb_we |-> wb_addr != '0)
        else $error("register write to r0 on the trace");

    quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !wb_we)
        else $error("register write in the first cycle after reset");

endmodule

bind mips_core mips_core_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_we   (wb_we),
    .wb_addr (wb_addr),
    .halted  (halted)
);

`default_nettype wire

// File: rtl/mips_core.sv
`include "mips_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  logic                     prog_we,
    input  logic [`MIPS_IMEM_AW-1:0] prog_addr,
    input  pipe_pkg::word_t          prog_data,
    output logic                     wb_we,
    output pipe_pkg::reg_t           wb_addr,
    output pipe_pkg::word_t          wb_data,
    output logic                     halted
);
    import pipe_pkg::*;

    logic    adv;
    logic    stall;
    logic    redirect;
    logic    br_uses_reg;
    word_t   target;
    word_t   mem_result;
    reg_t    rs;
    reg_t    rt;
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    wb_t     wb;
    fwd_t    fwd;

    // global run enable
    assign adv = run && !halted;

    assign wb_we   = wb.we;
    assign wb_addr = wb.addr;
    assign wb_data = wb.data;

    fetch_stage u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .adv       (adv),
        .stall     (stall),
        .flush     (redirect),
        .redirect  (redirect),
        .target    (target),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .if_id     (if_id)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .adv         (adv),
        .if_id       (if_id),
        .stall       (stall),
        .fwd         (fwd),
        .mem_result  (mem_result),
        .wb          (wb),
        .id_ex       (id_ex),
        .redirect    (redirect),
        .target      (target),
        .br_uses_reg (br_uses_reg),
        .rs          (rs),
        .rt          (rt)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .adv        (adv),
        .id_ex      (id_ex),
        .fwd        (fwd),
        .mem_result (mem_result),
        .wb         (wb),
        .ex_mem     (ex_mem)
    );

    memory_stage u_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .adv        (adv),
        .ex_mem     (ex_mem),
        .mem_result (mem_result),
        .wb         (wb),
        .halted     (halted)
    );

    hazard_unit u_hazard (
        .id_rs       (rs),
        .id_rt       (rt),
        .br_uses_reg (br_uses_reg),
        .id_ex       (id_ex),
        .ex_mem      (ex_mem),
        .wb          (wb),
        .fwd         (fwd),
        .stall       (stall)
    );

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  pipe_pkg::reg_t    id_rs,
    input  pipe_pkg::reg_t    id_rt,
    input  logic              br_uses_reg,
    input  pipe_pkg::id_ex_t  id_ex,
    input  pipe_pkg::ex_mem_t ex_mem,
    input  pipe_pkg::wb_t     wb,
    output pipe_pkg::fwd_t    fwd,
    output logic              stall
);
    import pipe_pkg::*;

    logic load_use;
    logic ex_hit;
    logic mem_load_hit;

    // MEM wins over WB, a load in MEM has no data yet
    function automatic fwd_sel_e pick(reg_t r, ex_mem_t m, wb_t w);
        if (r == '0) return FWD_REG;
        if (m.regwe && !m.ramtoreg && (m.rd == r)) return FWD_MEM;
        if (w.we && (w.addr == r)) return FWD_WB;
        return FWD_REG;
    endfunction

    function automatic logic hits(reg_t dst, reg_t a, reg_t b);
        return (dst != '0) && ((dst == a) || (dst == b));
    endfunction

    assign fwd.id_a  = pick(id_rs, ex_mem, wb);
    assign fwd.id_b  = pick(id_rt, ex_mem, wb);
    assign fwd.ex_a  = pick(id_ex.rs, ex_mem, wb);
    assign fwd.ex_b  = id_ex.ctrl.alusrc ? FWD_REG : pick(id_ex.rt, ex_mem, wb);
    assign fwd.ex_sd = id_ex.ctrl.ramwe ? pick(id_ex.rt, ex_mem, wb) : FWD_REG;

    assign load_use     = id_ex.ctrl.ramtoreg && hits(id_ex.rd, id_rs, id_rt);
    // branch compares in ID, so an EX result or a MEM load is too late
    assign ex_hit       = id_ex.ctrl.regwe && hits(id_ex.rd, id_rs, id_rt);
    assign mem_load_hit = ex_mem.ramtoreg && hits(ex_mem.rd, id_rs, id_rt);

    assign stall = load_use || (br_uses_reg && (ex_hit || mem_load_hit));

endmodule

`default_nettype wire

// File: rtl/memory_stage.sv
`include "mips_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              adv,
    input  pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::word_t   mem_result,
    output pipe_pkg::wb_t     wb,
    output logic              halted
);
    import pipe_pkg::*;

    word_t                    dmem [2**`MIPS_DMEM_AW];
    logic [`MIPS_DMEM_AW-1:0] addr;
    mem_wb_t                  mem_wb;

    assign addr       = ex_mem.result[`MIPS_DMEM_AW+1:2];
    assign mem_result = ex_mem.result;

    always_ff @(posedge clk) begin
        if (adv && ex_mem.ramwe) begin
            dmem[addr] <= ex_mem.sdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else if (adv) begin
            mem_wb.regwe    <= ex_mem.regwe;
            mem_wb.ramtoreg <= ex_mem.ramtoreg;
            mem_wb.syscall  <= ex_mem.syscall;
            mem_wb.rd       <= ex_mem.rd;
            mem_wb.result   <= ex_mem.result;
            mem_wb.ram_data <= dmem[addr];
        end
    end

    // r0 writes never show up
    assign wb.we   = adv && mem_wb.regwe && (mem_wb.rd != '0);
    assign wb.addr = mem_wb.rd;
    assign wb.data = mem_wb.ramtoreg ? mem_wb.ram_data : mem_wb.result;

    // syscall result holds v0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (adv && mem_wb.syscall && (mem_wb.result == word_t'(`MIPS_HALT_CODE))) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              adv,
    input  pipe_pkg::id_ex_t  id_ex,
    input  pipe_pkg::fwd_t    fwd,
    input  pipe_pkg::word_t   mem_result,
    input  pipe_pkg::wb_t     wb,
    output pipe_pkg::ex_mem_t ex_mem
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t a;
    word_t b;
    word_t sdata;
    word_t src_a;
    word_t src_b;
    word_t result;

    assign a     = fwd_pick(fwd.ex_a, id_ex.r1, mem_result, wb.data);
    assign b     = fwd_pick(fwd.ex_b, id_ex.r2, mem_result, wb.data);
    assign sdata = fwd_pick(fwd.ex_sd, id_ex.r2, mem_result, wb.data);

    // jal links pc + 4 into r31
    assign src_a = id_ex.ctrl.jal ? id_ex.pc : a;
    assign src_b = id_ex.ctrl.jal    ? word_t'(4)
                 : id_ex.ctrl.alusrc ? id_ex.imm
                 : b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: result = src_a - src_b;
            ALU_AND: result = src_a & src_b;
            ALU_OR:  result = src_a | src_b;
            ALU_SLT: result = word_t'($signed(src_a) < $signed(src_b));
            default: result = src_a + src_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (adv) begin
            ex_mem.pc       <= id_ex.pc;
            ex_mem.regwe    <= id_ex.ctrl.regwe;
            ex_mem.ramtoreg <= id_ex.ctrl.ramtoreg;
            ex_mem.ramwe    <= id_ex.ctrl.ramwe;
            ex_mem.syscall  <= id_ex.ctrl.syscall;
            ex_mem.rt       <= id_ex.rt;
            ex_mem.rd       <= id_ex.rd;
            ex_mem.result   <= result;
            ex_mem.sdata    <= sdata;
        end
    end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`include "mips_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              adv,
    input  pipe_pkg::if_id_t  if_id,
    input  logic              stall,
    input  pipe_pkg::fwd_t    fwd,
    input  pipe_pkg::word_t   mem_result,
    input  pipe_pkg::wb_t     wb,
    output pipe_pkg::id_ex_t  id_ex,
    output logic              redirect,
    output pipe_pkg::word_t   target,
    output logic              br_uses_reg,
    output pipe_pkg::reg_t    rs,
    output pipe_pkg::reg_t    rt
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam reg_t REG_V0 = 2;
    localparam reg_t REG_RA = 31;

    opcode_e     op;
    funct_e      funct;
    logic [15:0] imm16;
    ctrl_t       ctrl;
    logic        is_beq;
    logic        is_bne;
    logic        is_j;
    logic        use_rd;
    logic        zext;
    word_t       regs [2**`MIPS_RA_W];
    word_t       r1;
    word_t       r2;
    word_t       imm;
    word_t       pc4;
    reg_t        rd;

    assign op    = opcode_e'(if_id.instr[31:26]);
    assign funct = funct_e'(if_id.instr[5:0]);
    assign imm16 = if_id.instr[15:0];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        is_beq      = 1'b0;
        is_bne      = 1'b0;
        is_j        = 1'b0;
        use_rd      = 1'b0;
        zext        = 1'b0;
        case (op)
            OP_RTYPE: begin
                use_rd     = 1'b1;
                ctrl.regwe = 1'b1;
                case (funct)
                    FN_ADD: ctrl.alu_op = ALU_ADD;
                    FN_SUB: ctrl.alu_op = ALU_SUB;
                    FN_AND: ctrl.alu_op = ALU_AND;
                    FN_OR:  ctrl.alu_op = ALU_OR;
                    FN_SLT: ctrl.alu_op = ALU_SLT;
                    // passes v0 + 0 down to the halt check
                    FN_SYSCALL: begin
                        ctrl.regwe   = 1'b0;
                        ctrl.syscall = 1'b1;
                        ctrl.alusrc  = 1'b1;
                    end
                    default: ctrl.regwe = 1'b0;
                endcase
            end
            OP_ADDI: begin
                ctrl.regwe  = 1'b1;
                ctrl.alusrc = 1'b1;
            end
            OP_ANDI, OP_ORI: begin
                ctrl.regwe  = 1'b1;
                ctrl.alusrc = 1'b1;
                ctrl.alu_op = (op == OP_ANDI) ? ALU_AND : ALU_OR;
                zext        = 1'b1;
            end
            OP_LW: begin
                ctrl.regwe    = 1'b1;
                ctrl.ramtoreg = 1'b1;
                ctrl.alusrc   = 1'b1;
            end
            OP_SW: begin
                ctrl.ramwe  = 1'b1;
                ctrl.alusrc = 1'b1;
            end
            OP_BEQ: is_beq = 1'b1;
            OP_BNE: is_bne = 1'b1;
            OP_J:   is_j = 1'b1;
            OP_JAL: begin
                ctrl.regwe = 1'b1;
                ctrl.jal   = 1'b1;
            end
            default: ;
        endcase
    end

    // write port driven from WB, reads are combinational
    always_ff @(posedge clk) begin
        if (wb.we) begin
            regs[wb.addr] <= wb.data;
        end
    end

    assign rs = ctrl.syscall ? REG_V0 : if_id.instr[25:21];
    assign rt = if_id.instr[20:16];
    assign rd = ctrl.jal ? REG_RA : (use_rd ? if_id.instr[15:11] : rt);

    assign r1 = fwd_pick(fwd.id_a, (rs == '0) ? '0 : regs[rs], mem_result, wb.data);
    assign r2 = fwd_pick(fwd.id_b, (rt == '0) ? '0 : regs[rt], mem_result, wb.data);

    assign imm = ctrl.syscall ? '0
               : zext ? {{(`MIPS_XLEN-16){1'b0}}, imm16}
               : {{(`MIPS_XLEN-16){imm16[15]}}, imm16};

    // branch and jump resolution
    assign pc4         = if_id.pc + word_t'(4);
    assign br_uses_reg = is_beq || is_bne;
    assign redirect    = (is_beq && (r1 == r2)) || (is_bne && (r1 != r2)) || is_j || ctrl.jal;
    assign target      = br_uses_reg ? pc4 + (imm << 2)
                       : {pc4[`MIPS_XLEN-1:28], if_id.instr[25:0], 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (adv) begin
            if (stall) begin
                id_ex <= '0;
            end else begin
                id_ex.pc   <= if_id.pc;
                id_ex.ctrl <= ctrl;
                id_ex.rs   <= rs;
                id_ex.rt   <= rt;
                id_ex.rd   <= rd;
                id_ex.imm  <= imm;
                id_ex.r1   <= r1;
                id_ex.r2   <= r2;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
`include "mips_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     adv,
    input  logic                     stall,
    input  logic                     flush,
    input  logic                     redirect,
    input  pipe_pkg::word_t          target,
    input  logic                     prog_we,
    input  logic [`MIPS_IMEM_AW-1:0] prog_addr,
    input  pipe_pkg::word_t          prog_data,
    output pipe_pkg::if_id_t         if_id
);
    import pipe_pkg::*;

    word_t imem [2**`MIPS_IMEM_AW];
    word_t pc;
    word_t pc_next;

    // program load works whether or not the core runs
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // static not-taken fetch
    assign pc_next = redirect ? target : pc + word_t'(4);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (adv && !stall) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id <= '0;
        end else if (adv && !stall) begin
            // all-zero word decodes as a no-op
            if (flush) begin
                if_id <= '0;
            end else begin
                if_id.pc    <= pc;
                if_id.instr <= imem[pc[`MIPS_IMEM_AW+1:2]];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/pipe_pkg.sv
`include "mips_cfg.svh"
`default_nettype none

package pipe_pkg;
    import isa_pkg::*;

    typedef logic [`MIPS_XLEN-1:0] word_t;
    typedef logic [`MIPS_RA_W-1:0] reg_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic    regwe;
        logic    ramtoreg;
        logic    ramwe;
        logic    alusrc;
        logic    jal;
        logic    syscall;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        reg_t  rs;
        reg_t  rt;
        reg_t  rd;
        word_t imm;
        word_t r1;
        word_t r2;
    } id_ex_t;

    typedef struct packed {
        word_t pc;
        logic  regwe;
        logic  ramtoreg;
        logic  ramwe;
        logic  syscall;
        reg_t  rt;
        reg_t  rd;
        word_t result;
        word_t sdata;
    } ex_mem_t;

    typedef struct packed {
        logic  regwe;
        logic  ramtoreg;
        logic  syscall;
        reg_t  rd;
        word_t result;
        word_t ram_data;
    } mem_wb_t;

    typedef struct packed {
        logic  we;
        reg_t  addr;
        word_t data;
    } wb_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        fwd_sel_e id_a;
        fwd_sel_e id_b;
        fwd_sel_e ex_a;
        fwd_sel_e ex_b;
        fwd_sel_e ex_sd;
    } fwd_t;

    // operand mux shared by ID and EX
    function automatic word_t fwd_pick(fwd_sel_e sel, word_t rf, word_t mem, word_t wbd);
        case (sel)
            FWD_MEM: return mem;
            FWD_WB:  return wbd;
            default: return rf;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // funct field of opcode 0
    typedef enum logic [5:0] {
        FN_SYSCALL = 6'h0c,
        FN_ADD     = 6'h20,
        FN_SUB     = 6'h22,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_SLT     = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

endpackage

`default_nettype wire

// File: include/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

`default_nettype none

// datapath width
`define MIPS_XLEN 32

// word address widths of the two memories
`define MIPS_IMEM_AW 8
`define MIPS_DMEM_AW 8

`define MIPS_RA_W 5

// v0 value that stops the core on syscall
`define MIPS_HALT_CODE 10

`default_nettype wire

`endif
